/* project.f */
+incdir+hdl
hdl/isaPkg.sv
hdl/pipePkg.sv
hdl/controlDecoder.sv
hdl/regFile.sv
hdl/idExRegister.sv
hdl/hazardUnit.sv
hdl/executeStage.sv
hdl/decodeExecute.sv
verification/clockGen.sv
verification/decodeExecuteTb.sv

/* Makefile */
SIM := obj_dir/decodeExecuteSim

all: run

build:
	verilator --binary --timing --assert -f project.f --top-module decodeExecuteTb \
		-o decodeExecuteSim

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "^=== PASS ===$$"

lint:
	verilator --lint-only --timing --assert -f project.f --top-module decodeExecuteTb

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* verification/decodeExecuteTb.sv */
`include "core_defs.svh"

module decodeExecuteTb;
    localparam int RESET_CYCLES = 16;
    localparam int ALU_N = 60;
    localparam int FWD_N = 80;
    localparam int MEM_N = 40;
    localparam int BR_N = 40;
    localparam int TEST_CYCLES = RESET_CYCLES + 31 + ALU_N + FWD_N + 2 * MEM_N + 8
                                 + 2 * BR_N + 7;

    logic              clk;
    logic              rst;
    logic [`XLEN-1:0]  instrD;
    logic [`XLEN-1:0]  pcD;
    pipePkg::fwdPort_t memFwd;
    pipePkg::fwdPort_t wbPort;
    pipePkg::exOut_t   exOut;
    logic              pcSrc;
    logic [`XLEN-1:0]  pcTarget;
    logic              stallD;
    logic              flushD;

    logic [`XLEN-1:0] shadow [`REG_COUNT]; // model of the register file.
    logic             mValid;
    logic [`XLEN-1:0] mInstr;
    logic [`XLEN-1:0] mPc;
    logic [`XLEN-1:0] mV1;
    logic [`XLEN-1:0] mV2;
    pipePkg::exOut_t  expOut;
    logic             expPcSrc;
    logic [`XLEN-1:0] expTarget;
    logic             expStall;
    logic [`XLEN-1:0] opA;
    logic [`XLEN-1:0] opB;
    logic [`XLEN-1:0] immE;
    integer           seed;
    logic [`XLEN-1:0] pcNext;

    clockGen clock (.clk(clk));

    decodeExecute uut (
        .clk      (clk),
        .rst      (rst),
        .instrD   (instrD),
        .pcD      (pcD),
        .memFwd   (memFwd),
        .wbPort   (wbPort),
        .exOut    (exOut),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget),
        .stallD   (stallD),
        .flushD   (flushD)
    );

    function automatic logic [`XLEN-1:0] rType(input logic [2:0] f3, input logic alt,
                                               input logic [4:0] rd, rs1, rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [`XLEN-1:0] iType(input logic [6:0] op, input logic [2:0] f3,
                                               input logic [4:0] rd, rs1,
                                               input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [`XLEN-1:0] sType(input logic [4:0] rs1, rs2,
                                               input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [`XLEN-1:0] bType(input logic [2:0] f3, input logic [4:0] rs1,
                                               input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [`XLEN-1:0] jType(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    // sign-extended immediate by instruction format.
    function automatic logic [`XLEN-1:0] immOf(input logic [`XLEN-1:0] i);
        case (i[6:0])
            7'h13, 7'h03: return {{20{i[31]}}, i[31:20]};
            7'h23:        return {{20{i[31]}}, i[31:25], i[11:7]};
            7'h63:        return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
            7'h6f:        return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
            default:      return '0;
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] aluCalc(input logic [2:0] f3, input logic alt,
                                                 input logic [`XLEN-1:0] a, b);
        logic [`XLEN-1:0] r;
        case (f3)
            3'd0: r = alt ? a - b : a + b;
            3'd1: r = a << b[4:0];
            3'd2: r = {31'b0, $signed(a) < $signed(b)};
            3'd3: r = {31'b0, a < b};
            3'd4: r = a ^ b;
            3'd5: begin
                if (alt)
                    r = $signed(a) >>> b[4:0];
                else
                    r = a >> b[4:0];
            end
            3'd6: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [`XLEN-1:0] a, b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            default: return 1'b0;
        endcase
    endfunction

    // memory stage first, then writeback.
    function automatic logic [`XLEN-1:0] forwardVal(input logic [4:0] src,
                                                    input logic [`XLEN-1:0] regVal,
                                                    input pipePkg::fwdPort_t m, w);
        if (m.regWrite && m.rd != 5'd0 && m.rd == src)
            return m.value;
        if (w.regWrite && w.rd != 5'd0 && w.rd == src)
            return w.value;
        return regVal;
    endfunction

    function automatic logic [`XLEN-1:0] readShadow(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        if (wbPort.regWrite && wbPort.rd == addr)
            return wbPort.value; // same-cycle write.
        return shadow[addr];
    endfunction

    always_comb begin
        immE      = immOf(mInstr);
        opA       = forwardVal(mInstr[19:15], mV1, memFwd, wbPort);
        opB       = forwardVal(mInstr[24:20], mV2, memFwd, wbPort);
        expOut    = '0;
        expPcSrc  = 1'b0;
        expTarget = mPc + immE;
        if (mValid) begin
            expOut.rd        = mInstr[11:7];
            expOut.pcPlus4   = mPc + 32'd4;
            expOut.writeData = opB;
            expOut.aluResult = opA + opB;
            case (mInstr[6:0])
                7'h33: begin
                    expOut.regWrite  = 1'b1;
                    expOut.aluResult = aluCalc(mInstr[14:12], mInstr[30], opA, opB);
                end
                7'h13: begin
                    expOut.regWrite  = 1'b1;
                    expOut.aluResult = aluCalc(mInstr[14:12],
                                               mInstr[30] && mInstr[14:12] == 3'd5, opA, immE);
                end
                7'h03: begin
                    expOut.regWrite  = 1'b1;
                    expOut.resultSrc = isaPkg::RES_MEM;
                    expOut.aluResult = opA + immE;
                end
                7'h23: begin
                    expOut.memWrite  = 1'b1;
                    expOut.aluResult = opA + immE;
                end
                7'h63: begin
                    expOut.aluResult = opA - opB;
                    expPcSrc         = branchTaken(mInstr[14:12], opA, opB);
                end
                7'h6f: begin
                    expOut.regWrite  = 1'b1;
                    expOut.resultSrc = isaPkg::RES_PC4;
                    expPcSrc         = 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign expStall = mInstr[6:0] == 7'h03 && mInstr[11:7] != 5'd0 &&
                      (mInstr[11:7] == instrD[19:15] || mInstr[11:7] == instrD[24:20]);

    always @(posedge clk) begin
        if (rst || expStall || expPcSrc) begin
            mValid <= 1'b0;
            mInstr <= '0;
            mPc    <= '0;
            mV1    <= '0;
            mV2    <= '0;
        end else begin
            mValid <= 1'b1;
            mInstr <= instrD;
            mPc    <= pcD;
            mV1    <= readShadow(instrD[19:15]);
            mV2    <= readShadow(instrD[24:20]);
        end
        if (wbPort.regWrite && wbPort.rd != 5'd0)
            shadow[wbPort.rd] <= wbPort.value;
    end

    task automatic abortRun(input string why);
        $display("=== FAIL ===");
        $fatal(1, "%s", why);
    endtask

    exOutCheck: assert property (@(posedge clk) disable iff (rst) exOut == expOut)
        else begin
            $display("FAILED %0t exOut expected %h got %h", $time, $sampled(expOut),
                     $sampled(exOut));
            abortRun("exOut does not match the model");
        end
    pcSrcCheck: assert property (@(posedge clk) disable iff (rst) pcSrc == expPcSrc)
        else begin
            $display("FAILED %0t pcSrc expected %b got %b", $time, $sampled(expPcSrc),
                     $sampled(pcSrc));
            abortRun("pcSrc does not match the model");
        end
    targetCheck: assert property (@(posedge clk) disable iff (rst) pcTarget == expTarget)
        else begin
            $display("FAILED %0t pcTarget expected %h got %h", $time, $sampled(expTarget),
                     $sampled(pcTarget));
            abortRun("pcTarget does not match the model");
        end
    stallCheck: assert property (@(posedge clk) disable iff (rst) stallD == expStall)
        else begin
            $display("FAILED %0t stallD expected %b got %b", $time, $sampled(expStall),
                     $sampled(stallD));
            abortRun("stallD does not match the model");
        end
    flushCheck: assert property (@(posedge clk) disable iff (rst) flushD == expPcSrc)
        else begin
            $display("FAILED %0t flushD expected %b got %b", $time, $sampled(expPcSrc),
                     $sampled(flushD));
            abortRun("flushD does not match the model");
        end

    // holds the instruction while the DUT stalls decode.
    task automatic issue(input logic [`XLEN-1:0] ins, input pipePkg::fwdPort_t m,
                         input pipePkg::fwdPort_t w);
        @(negedge clk);
        while (stallD)
            @(negedge clk);
        @(posedge clk);
        instrD <= ins;
        pcD    <= pcNext;
        memFwd <= m;
        wbPort <= w;
        pcNext = pcNext + 32'd4;
    endtask

    task automatic randomAlu(input logic [4:0] mask, input pipePkg::fwdPort_t m,
                             input pipePkg::fwdPort_t w);
        logic [`XLEN-1:0] r;
        r = $random(seed);
        if (r[31])
            issue(rType(r[2:0], r[3], r[8:4], r[13:9] & mask, r[18:14] & mask), m, w);
        else
            issue(iType(7'h13, r[2:0], r[8:4], r[13:9] & mask, r[30:19]), m, w);
    endtask

    initial begin
        #((TEST_CYCLES + 40) * 4);
        $display("watchdog expired before the tests finished");
        abortRun("watchdog timeout");
    end

    initial begin
        pipePkg::fwdPort_t m;
        pipePkg::fwdPort_t w;
        logic [`XLEN-1:0]  r;
        seed   = 25;
        pcNext = '0;
        rst    <= 1'b1;
        instrD <= '0;
        pcD    <= '0;
        memFwd <= '0;
        wbPort <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 1; i < `REG_COUNT; i++) begin
            w.regWrite = 1'b1;
            w.rd       = i[4:0];
            w.value    = $random(seed);
            issue('0, '0, w);
        end
        repeat (ALU_N) randomAlu(5'h1f, '0, '0);
        repeat (FWD_N) begin
            r = $random(seed);
            m = {r[0], 3'b0, r[2:1], 32'h0}; // x0..x3 only, so hits are frequent.
            w = {r[3], 3'b0, r[5:4], 32'h0};
            m.value = $random(seed);
            w.value = $random(seed);
            randomAlu(5'h03, m, w);
        end
        repeat (MEM_N) begin
            r = $random(seed);
            if (r[31])
                issue(iType(7'h03, 3'b010, r[4:0] & 5'h07, r[9:5], r[21:10]), '0, '0);
            else
                issue(sType(r[9:5], r[14:10] & 5'h07, r[26:15]), '0, '0);
        end
        issue(iType(7'h03, 3'b010, 5'd5, 5'd2, 12'h008), '0, '0);
        issue(rType(3'b000, 1'b0, 5'd6, 5'd5, 5'd3), '0, '0);
        issue(iType(7'h03, 3'b010, 5'd9, 5'd1, 12'hffc), '0, '0);
        issue(sType(5'd4, 5'd9, 12'h010), '0, '0);
        repeat (BR_N) begin
            r = $random(seed);
            if (r[1:0] == 2'd3)
                issue(jType(r[6:2], {r[31:12], 1'b0}), '0, '0);
            else
                issue(bType({r[2], 1'b0, r[3]}, {3'b0, r[5:4]}, {3'b0, r[7:6]},
                            {r[31:20], 1'b0}), '0, '0);
            randomAlu(5'h1f, '0, '0); // squashed when taken.
        end
        repeat (4) issue('0, '0, '0);
        repeat (3) @(posedge clk);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* verification/clockGen.sv */
module clockGen (
    output logic clk
);
    initial clk = 1'b0;

    always #2 clk = ~clk; // period of 4.

endmodule

/* hdl/decodeExecute.sv */
`include "core_defs.svh"

module decodeExecute (
    input  logic               clk,
    input  logic               rst,
    input  logic [`XLEN-1:0]   instrD,
    input  logic [`XLEN-1:0]   pcD,
    input  pipePkg::fwdPort_t  memFwd,
    input  pipePkg::fwdPort_t  wbPort,
    output pipePkg::exOut_t    exOut,
    output logic               pcSrc,
    output logic [`XLEN-1:0]   pcTarget,
    output logic               stallD,
    output logic               flushD
);
    pipePkg::decodeCtrl_t   ctrlD;
    pipePkg::idExBundle_t   bundleD;
    pipePkg::idExBundle_t   bundleE;
    logic [`XLEN-1:0]       immExtD;
    logic [`XLEN-1:0]       rd1D;
    logic [`XLEN-1:0]       rd2D;
    logic [`REG_ADDR_W-1:0] rs1D;
    logic [`REG_ADDR_W-1:0] rs2D;
    logic [`REG_ADDR_W-1:0] rdD;
    logic                   flushE;

    controlDecoder decoder (
        .instr  (instrD),
        .ctrl   (ctrlD),
        .immExt (immExtD),
        .rs1    (rs1D),
        .rs2    (rs2D),
        .rd     (rdD)
    );

    regFile regs (
        .clk (clk),
        .rs1 (rs1D),
        .rs2 (rs2D),
        .wr  (wbPort),
        .rd1 (rd1D),
        .rd2 (rd2D)
    );

    always_comb begin
        bundleD.ctrl    = ctrlD;
        bundleD.pc      = pcD;
        bundleD.immExt  = immExtD;
        bundleD.pcPlus4 = pcD + 4; // return address for jal.
        bundleD.rd1     = rd1D;
        bundleD.rd2     = rd2D;
        bundleD.rd      = rdD;
        bundleD.rs1     = rs1D;
        bundleD.rs2     = rs2D;
    end

    idExRegister idEx (
        .clk   (clk),
        .rst   (rst),
        .flush (flushE),
        .dIn   (bundleD),
        .eOut  (bundleE)
    );

    hazardUnit hazards (
        .rs1D     (rs1D),
        .rs2D     (rs2D),
        .exBundle (bundleE),
        .pcSrc    (pcSrc),
        .stallD   (stallD),
        .flushD   (flushD),
        .flushE   (flushE)
    );

    executeStage execute (
        .ex       (bundleE),
        .memFwd   (memFwd),
        .wbPort   (wbPort),
        .result   (exOut),
        .pcSrc    (pcSrc),
        .pcTarget (pcTarget)
    );

endmodule

/* hdl/executeStage.sv */
`include "core_defs.svh"

module executeStage (
    input  pipePkg::idExBundle_t ex,
    input  pipePkg::fwdPort_t    memFwd,
    input  pipePkg::fwdPort_t    wbPort,
    output pipePkg::exOut_t      result,
    output logic                 pcSrc,
    output logic [`XLEN-1:0]     pcTarget
);
    logic [`XLEN-1:0] fwdA;
    logic [`XLEN-1:0] fwdB;
    logic [`XLEN-1:0] opB;
    logic [4:0]       shamt;
    logic [`XLEN-1:0] aluResult;
    logic             takeBranch;

    function automatic logic portHit(
        input pipePkg::fwdPort_t      p,
        input logic [`REG_ADDR_W-1:0] src
    );
        return p.regWrite && p.rd != '0 && p.rd == src;
    endfunction

    // memory stage is younger than writeback.
    function automatic logic [`XLEN-1:0] forward(
        input logic [`REG_ADDR_W-1:0] src,
        input logic [`XLEN-1:0]       regVal,
        input pipePkg::fwdPort_t      m,
        input pipePkg::fwdPort_t      w
    );
        if (portHit(m, src))
            return m.value;
        if (portHit(w, src))
            return w.value;
        return regVal;
    endfunction

    assign fwdA  = forward(ex.rs1, ex.rd1, memFwd, wbPort);
    assign fwdB  = forward(ex.rs2, ex.rd2, memFwd, wbPort);
    assign opB   = ex.ctrl.aluSrc ? ex.immExt : fwdB;
    assign shamt = opB[4:0];

    always_comb begin
        case (ex.ctrl.aluOp)
            isaPkg::ADD:  aluResult = fwdA + opB;
            isaPkg::SUB:  aluResult = fwdA - opB;
            isaPkg::AND:  aluResult = fwdA & opB;
            isaPkg::OR:   aluResult = fwdA | opB;
            isaPkg::XOR:  aluResult = fwdA ^ opB;
            isaPkg::SLT:  aluResult = {{(`XLEN-1){1'b0}}, $signed(fwdA) < $signed(opB)};
            isaPkg::SLTU: aluResult = {{(`XLEN-1){1'b0}}, fwdA < opB};
            isaPkg::SLL:  aluResult = fwdA << shamt;
            isaPkg::SRL:  aluResult = fwdA >> shamt;
            isaPkg::SRA:  aluResult = $signed(fwdA) >>> shamt;
            default:      aluResult = '0;
        endcase
    end

    // compares the forwarded registers, not opB.
    always_comb begin
        case (ex.ctrl.funct3)
            isaPkg::BEQ: takeBranch = (fwdA == fwdB);
            isaPkg::BNE: takeBranch = (fwdA != fwdB);
            isaPkg::BLT: takeBranch = ($signed(fwdA) < $signed(fwdB));
            isaPkg::BGE: takeBranch = ($signed(fwdA) >= $signed(fwdB));
            default:     takeBranch = 1'b0;
        endcase
    end

    assign pcSrc    = ex.ctrl.jump || (ex.ctrl.branch && takeBranch);
    assign pcTarget = ex.pc + ex.immExt;

    always_comb begin
        result.regWrite  = ex.ctrl.regWrite;
        result.memWrite  = ex.ctrl.memWrite;
        result.resultSrc = ex.ctrl.resultSrc;
        result.aluResult = aluResult;
        result.writeData = fwdB; // store data.
        result.rd        = ex.rd;
        result.pcPlus4   = ex.pcPlus4;
    end

endmodule

/* hdl/hazardUnit.sv */
`include "core_defs.svh"

module hazardUnit (
    input  logic [`REG_ADDR_W-1:0] rs1D,
    input  logic [`REG_ADDR_W-1:0] rs2D,
    input  pipePkg::idExBundle_t   exBundle,
    input  logic                   pcSrc,
    output logic                   stallD,
    output logic                   flushD,
    output logic                   flushE
);
    logic loadInEx;
    logic loadUse;

    assign loadInEx = (exBundle.ctrl.resultSrc == isaPkg::RES_MEM) && (exBundle.rd != '0);
    assign loadUse  = loadInEx && (exBundle.rd == rs1D || exBundle.rd == rs2D);

    assign stallD = loadUse;
    assign flushD = pcSrc;            // drop the wrong-path fetch.
    assign flushE = loadUse || pcSrc; // bubble into execute.

endmodule

/* hdl/idExRegister.sv */
module idExRegister (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,
    input  pipePkg::idExBundle_t dIn,
    output pipePkg::idExBundle_t eOut
);
    // a flush turns the slot into a bubble.
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            eOut <= '0;
        end else begin
            eOut <= dIn;
        end
    end

endmodule

/* hdl/regFile.sv */
`include "core_defs.svh"

module regFile (
    input  logic                   clk,
    input  logic [`REG_ADDR_W-1:0] rs1,
    input  logic [`REG_ADDR_W-1:0] rs2,
    input  pipePkg::fwdPort_t      wr,
    output logic [`XLEN-1:0]       rd1,
    output logic [`XLEN-1:0]       rd2
);
    logic [`XLEN-1:0] regs [`REG_COUNT];

    function automatic logic [`XLEN-1:0] readPort(
        input logic [`REG_ADDR_W-1:0] addr,
        input pipePkg::fwdPort_t      w,
        input logic [`XLEN-1:0]       stored
    );
        if (addr == '0)
            return '0; // x0.
        if (w.regWrite && w.rd == addr)
            return w.value; // write-through.
        return stored;
    endfunction

    always_ff @(posedge clk) begin
        if (wr.regWrite && wr.rd != '0)
            regs[wr.rd] <= wr.value;
    end

    assign rd1 = readPort(rs1, wr, regs[rs1]);
    assign rd2 = readPort(rs2, wr, regs[rs2]);

endmodule

/* hdl/controlDecoder.sv */
`include "core_defs.svh"

module controlDecoder (
    input  logic [`XLEN-1:0]       instr,
    output pipePkg::decodeCtrl_t   ctrl,
    output logic [`XLEN-1:0]       immExt,
    output logic [`REG_ADDR_W-1:0] rs1,
    output logic [`REG_ADDR_W-1:0] rs2,
    output logic [`REG_ADDR_W-1:0] rd
);
    logic [6:0]     opcode;
    logic [2:0]     funct3;
    logic           isOp;
    isaPkg::aluOp_t aluDec;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign isOp   = (opcode == isaPkg::OP);

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    // alu decoder, shared by OP and OP_IMM.
    always_comb begin
        case (funct3)
            3'b000:  aluDec = (isOp && instr[30]) ? isaPkg::SUB : isaPkg::ADD;
            3'b001:  aluDec = isaPkg::SLL;
            3'b010:  aluDec = isaPkg::SLT;
            3'b011:  aluDec = isaPkg::SLTU;
            3'b100:  aluDec = isaPkg::XOR;
            3'b101:  aluDec = instr[30] ? isaPkg::SRA : isaPkg::SRL;
            3'b110:  aluDec = isaPkg::OR;
            default: aluDec = isaPkg::AND;
        endcase
    end

    always_comb begin
        ctrl   = '0;
        immExt = '0;
        case (opcode)
            isaPkg::OP: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluDec;
                ctrl.funct3   = funct3;
            end
            isaPkg::OP_IMM: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = aluDec;
                ctrl.funct3   = funct3;
                immExt        = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            isaPkg::LOAD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrc    = 1'b1;
                ctrl.resultSrc = isaPkg::RES_MEM;
                ctrl.aluOp     = isaPkg::ADD;
                ctrl.funct3    = funct3;
                immExt         = {{(`XLEN-12){instr[31]}}, instr[31:20]};
            end
            isaPkg::STORE: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = isaPkg::ADD;
                ctrl.funct3   = funct3;
                immExt        = {{(`XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            end
            isaPkg::BRANCH: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = isaPkg::SUB;
                ctrl.funct3 = funct3;
                immExt      = {{(`XLEN-12){instr[31]}}, instr[7], instr[30:25],
                               instr[11:8], 1'b0};
            end
            isaPkg::JAL: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = isaPkg::RES_PC4;
                ctrl.aluOp     = isaPkg::ADD;
                immExt         = {{(`XLEN-20){instr[31]}}, instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            end
            default: ; // unsupported, stays all zero.
        endcase
    end

endmodule

/* hdl/pipePkg.sv */
`include "core_defs.svh"

package pipePkg;

    typedef struct packed {
        logic               regWrite;
        logic               memWrite;
        logic               jump;
        logic               branch;
        logic               aluSrc;     // immediate as operand b.
        isaPkg::resultSrc_t resultSrc;
        isaPkg::aluOp_t     aluOp;
        logic [2:0]         funct3;     // branch condition select.
    } decodeCtrl_t;

    typedef struct packed {
        decodeCtrl_t            ctrl;
        logic [`XLEN-1:0]       pc;
        logic [`XLEN-1:0]       immExt;
        logic [`XLEN-1:0]       pcPlus4;
        logic [`XLEN-1:0]       rd1;
        logic [`XLEN-1:0]       rd2;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`REG_ADDR_W-1:0] rs1;
        logic [`REG_ADDR_W-1:0] rs2;
    } idExBundle_t;

    typedef struct packed {
        logic                   regWrite;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       value;
    } fwdPort_t;

    typedef struct packed {
        logic                   regWrite;
        logic                   memWrite;
        isaPkg::resultSrc_t     resultSrc;
        logic [`XLEN-1:0]       aluResult;
        logic [`XLEN-1:0]       writeData;
        logic [`REG_ADDR_W-1:0] rd;
        logic [`XLEN-1:0]       pcPlus4;
    } exOut_t;

endpackage

/* hdl/isaPkg.sv */
package isaPkg;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [4:0] {
        ADD  = 5'd0,
        SUB  = 5'd1,
        AND  = 5'd2,
        OR   = 5'd3,
        XOR  = 5'd4,
        SLT  = 5'd5,
        SLTU = 5'd6,
        SLL  = 5'd7,
        SRL  = 5'd8,
        SRA  = 5'd9
    } aluOp_t;

    typedef enum logic [1:0] {
        RES_ALU = 2'd0,
        RES_MEM = 2'd1,
        RES_PC4 = 2'd2
    } resultSrc_t;

    typedef enum logic [2:0] {
        BEQ = 3'b000,
        BNE = 3'b001,
        BLT = 3'b100,
        BGE = 3'b101
    } branchFn_t;

endpackage

/* hdl/core_defs.svh */
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath width in bits.
`define XLEN 32

// register index width.
`define REG_ADDR_W 5

// architectural registers x0..x31.
`define REG_COUNT 32

`endif
